// ==== src.f ====
hw/dtpu_pkg.sv
hw/dtpu_csr.sv
hw/dtpu_weight_mem.sv
hw/dtpu_skew.sv
hw/dtpu_mac_cell.sv
hw/dtpu_systolic_array.sv
hw/dtpu_ctrl.sv
hw/dtpu_core.sv
bench/tb_clock_gen.sv
bench/tb_dtpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_dtpu -o sim_dtpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dtpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== bench/tb_dtpu.sv ====
`timescale 1ns/10ps

module tb_dtpu;
    import dtpu_pkg::*;

    logic clk, rst_n;
    logic [CSR_AW-1:0] csr_address;
    logic [7:0] csr_din, csr_dout;
    logic csr_ce, csr_we;
    logic [WMEM_AW-1:0] wm_address;
    logic [FIFO_W-1:0] wm_din, wm_dout;
    logic wm_ce, wm_we;
    logic infifo_is_empty, infifo_read;
    logic [FIFO_W-1:0] infifo_dout;
    logic outfifo_is_full, outfifo_write;
    logic [FIFO_W-1:0] outfifo_din;
    logic cs_continue, cs_done, cs_idle, cs_ready, cs_start;

    // Models of the FIFOs and the weight memory
    logic [FIFO_W-1:0] in_q [$];
    logic [FIFO_W-1:0] exp_q [$];
    logic [FIFO_W-1:0] wmem [WMEM_DEPTH];

    logic [31:0] seed = 32'hdecbd4c1;
    int errors = 0;
    int checks = 0;
    int writes_seen;
    int ready_seen;
    logic active = 1'b0;
    logic full_mode = 1'b0;
    logic timed_out = 1'b0;
    logic [WMEM_AW-1:0] waddr_cur;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    dtpu_core dut0 (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Sum over k of x[k] * w(k, j), three 12-bit fields
    function automatic logic [FIFO_W-1:0] expected_word(logic [FIFO_W-1:0] xw,
                                                        logic [FIFO_W-1:0] ww);
        logic [FIFO_W-1:0] res;
        logic [ACC_W-1:0] sum;
        res = '0;
        for (int j = 0; j < COLS; j++) begin
            sum = '0;
            for (int k = 0; k < ROWS; k++) begin
                sum = sum + ACC_W'(xw[4*k +: 4]) * ACC_W'(ww[4*(k*COLS+j) +: 4]);
            end
            res[ACC_W*j +: ACC_W] = sum;
        end
        return res;
    endfunction

    task automatic check_val(string name, logic [FIFO_W-1:0] exp, logic [FIFO_W-1:0] act);
        checks++;
        assert (exp === act) else begin
            $display("error %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Counts a wait that ran out of time and stops further runs
    task automatic report_timeout(string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    ////////////////////////////////////////////////////////////
    // Host port tasks, called on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic csr_write(logic [CSR_AW-1:0] addr, logic [7:0] data);
        csr_address = addr;
        csr_din = data;
        csr_ce = 1'b1;
        csr_we = 1'b1;
        @(negedge clk);
        csr_ce = 1'b0;
        csr_we = 1'b0;
    endtask

    task automatic csr_read(logic [CSR_AW-1:0] addr, output logic [7:0] data);
        csr_address = addr;
        csr_ce = 1'b1;
        csr_we = 1'b0;
        @(negedge clk);
        csr_ce = 1'b0;
        data = csr_dout;
    endtask

    task automatic wm_access(logic [WMEM_AW-1:0] addr, logic we, logic [FIFO_W-1:0] data,
                             output logic [FIFO_W-1:0] rdata);
        wm_address = addr;
        wm_din = data;
        wm_ce = 1'b1;
        wm_we = we;
        @(negedge clk);
        wm_ce = 1'b0;
        wm_we = 1'b0;
        rdata = wm_dout;
    endtask

    ////////////////////////////////////////////////////////////
    // FIFO drivers and output monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (active) begin
            infifo_is_empty <= (in_q.size() == 0) || (lcg_next() % 4 == 0);
            infifo_dout <= (in_q.size() == 0) ? '0 : in_q[0];
            outfifo_is_full <= full_mode && (lcg_next() % 3 == 0);
        end else begin
            infifo_is_empty <= 1'b1;
            outfifo_is_full <= 1'b0;
        end
    end

    // Outputs sampled on the rising edge, before any register update
    always @(posedge clk) begin
        if (rst_n) begin
            // Ready belongs to the read of the last queued vector
            if (cs_ready) begin
                ready_seen++;
                assert (infifo_read && in_q.size() == 1) else begin
                    $display("cs_ready pulsed outside the read of the last input vector");
                    errors++;
                end
            end
            if (infifo_read) begin
                assert (in_q.size() > 0 && !infifo_is_empty) else begin
                    $display("input FIFO read while empty");
                    errors++;
                end
                if (in_q.size() > 0) begin
                    exp_q.push_back(expected_word(in_q[0], wmem[waddr_cur]));
                    void'(in_q.pop_front());
                end
            end
            if (outfifo_write) begin
                writes_seen++;
                assert (!outfifo_is_full) else begin
                    $display("output FIFO written while full");
                    errors++;
                end
                assert (exp_q.size() > 0) else begin
                    $display("output word written with no result pending");
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    check_val("result", exp_q.pop_front(), outfifo_din);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // One run
    ////////////////////////////////////////////////////////////

    task automatic run(int count, logic [WMEM_AW-1:0] waddr, logic full_on, logic busy_chk);
        logic [7:0] rb;
        int n;
        if (timed_out) return;
        csr_write(CSR_COUNT_LO, count[7:0]);
        csr_write(CSR_COUNT_HI, count[15:8]);
        csr_write(CSR_WADDR, 8'(waddr));
        waddr_cur = waddr;
        for (int i = 0; i < count; i++) begin
            in_q.push_back({lcg_next(), lcg_next()});
        end
        writes_seen = 0;
        ready_seen = 0;
        full_mode = full_on;
        active <= 1'b1;
        cs_start = 1'b1;
        @(negedge clk);
        cs_start = 1'b0;
        if (busy_chk) begin
            csr_read(CSR_STATUS, rb);
            check_val("status busy", 64'd1, 64'(rb));
        end
        n = 0;
        while (!cs_done && n < 5000) begin
            @(negedge clk);
            n++;
        end
        if (!cs_done) begin
            report_timeout("cs_done");
            return;
        end
        check_val("write count", 64'(count), 64'(writes_seen));
        check_val("ready pulses", (count == 0) ? 64'd0 : 64'd1, 64'(ready_seen));
        check_val("pending results", 64'd0, 64'(exp_q.size()));
        check_val("unread inputs", 64'd0, 64'(in_q.size()));
        repeat (5) @(negedge clk);
        check_val("done held", 64'd1, 64'(cs_done));
        check_val("idle while done", 64'd0, 64'(cs_idle));
        cs_continue = 1'b1;
        @(negedge clk);
        cs_continue = 1'b0;
        n = 0;
        while (!cs_idle && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!cs_idle) report_timeout("cs_idle");
        active <= 1'b0;
    endtask

    initial begin
        logic [7:0] rb;
        logic [FIFO_W-1:0] wd;
        logic [FIFO_W-1:0] rd;
        logic [WMEM_AW-1:0] wa1;
        logic [WMEM_AW-1:0] wa2;
        int n;
        csr_address = '0;
        csr_din = '0;
        csr_ce = 1'b0;
        csr_we = 1'b0;
        wm_address = '0;
        wm_din = '0;
        wm_ce = 1'b0;
        wm_we = 1'b0;
        infifo_is_empty = 1'b1;
        infifo_dout = '0;
        outfifo_is_full = 1'b0;
        cs_continue = 1'b0;
        cs_start = 1'b0;
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) report_timeout("reset release");
        @(negedge clk);

        // Reset state
        check_val("idle after reset", 64'd1, 64'(cs_idle));
        check_val("done after reset", 64'd0, 64'(cs_done));
        check_val("write after reset", 64'd0, 64'(outfifo_write));
        check_val("read after reset", 64'd0, 64'(infifo_read));
        check_val("ready after reset", 64'd0, 64'(cs_ready));

        // CSR readback
        wd = 64'(lcg_next());
        csr_write(CSR_COUNT_LO, wd[7:0]);
        csr_write(CSR_COUNT_HI, wd[15:8]);
        csr_write(CSR_WADDR, {4'h0, wd[19:16]});
        csr_read(CSR_COUNT_LO, rb);
        check_val("csr count_lo", 64'(wd[7:0]), 64'(rb));
        csr_read(CSR_COUNT_HI, rb);
        check_val("csr count_hi", 64'(wd[15:8]), 64'(rb));
        csr_read(CSR_WADDR, rb);
        check_val("csr waddr", 64'(wd[19:16]), 64'(rb));
        csr_read(CSR_STATUS, rb);
        check_val("csr status idle", 64'd0, 64'(rb));
        csr_read(32'h0000_0100, rb);
        check_val("csr unmapped", 64'd0, 64'(rb));

        // Weight memory fill and readback
        for (int a = 0; a < WMEM_DEPTH; a++) begin
            wmem[a] = {lcg_next(), lcg_next()};
            wm_access(WMEM_AW'(a), 1'b1, wmem[a], rd);
        end
        for (int a = 0; a < WMEM_DEPTH; a++) begin
            wm_access(WMEM_AW'(a), 1'b0, '0, rd);
            check_val("weight readback", wmem[a], rd);
        end

        // Empties only, then back pressure, then a zero count, then back to wa1
        wa1 = WMEM_AW'(lcg_next());
        wa2 = wa1 + WMEM_AW'(1 + lcg_next() % 15);
        run(40, wa1, 1'b0, 1'b0);
        run(30, wa2, 1'b1, 1'b1);
        run(0, wa1, 1'b0, 1'b0);
        run(12, wa1, 1'b1, 1'b0);

        $display("errors %0d checks %0d", errors, checks);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Hard bound on simulated time
    initial begin
        #2000000;
        errors++;
        $display("simulation time limit reached");
        $display("errors %0d checks %0d", errors, checks);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 8 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== hw/dtpu_core.sv ====
`timescale 1ns/10ps

module dtpu_core (
    input  logic                         clk,
    input  logic                         rst_n,
    // CSR port
    input  logic [dtpu_pkg::CSR_AW-1:0]  csr_address,
    input  logic [7:0]                   csr_din,
    output logic [7:0]                   csr_dout,
    input  logic                         csr_ce,
    input  logic                         csr_we,
    // Weight memory port
    input  logic [dtpu_pkg::WMEM_AW-1:0] wm_address,
    input  logic [dtpu_pkg::FIFO_W-1:0]  wm_din,
    output logic [dtpu_pkg::FIFO_W-1:0]  wm_dout,
    input  logic                         wm_ce,
    input  logic                         wm_we,
    // Input FIFO, first word fall through
    input  logic                         infifo_is_empty,
    input  logic [dtpu_pkg::FIFO_W-1:0]  infifo_dout,
    output logic                         infifo_read,
    // Output FIFO
    input  logic                         outfifo_is_full,
    output logic [dtpu_pkg::FIFO_W-1:0]  outfifo_din,
    output logic                         outfifo_write,
    // Run control
    input  logic                         cs_continue,
    output logic                         cs_done,
    output logic                         cs_idle,
    output logic                         cs_ready,
    input  logic                         cs_start
);
    import dtpu_pkg::*;

    run_cfg_t                cfg;
    logic                    busy;
    logic [WMEM_AW-1:0]      rd_addr;
    logic                    rd_en;
    weight_set_t             rd_data;
    logic                    weight_load;
    logic                    advance;
    lane_t     [ROWS-1:0]    in_lanes;
    lane_t     [ROWS-1:0]    x_lanes;
    in_vec_t                 x_vec;
    out_vec_t                psum;
    logic      [COLS-1:0]    psum_valid;
    res_lane_t [COLS-1:0]    res_raw;
    res_lane_t [COLS-1:0]    res_lanes;

    ////////////////////////////////////////////////////////////
    // Host side and control
    ////////////////////////////////////////////////////////////

    dtpu_csr u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_address(csr_address),
        .csr_din    (csr_din),
        .csr_ce     (csr_ce),
        .csr_we     (csr_we),
        .busy       (busy),
        .csr_dout   (csr_dout),
        .cfg        (cfg)
    );

    dtpu_weight_mem u_wmem (
        .clk       (clk),
        .wm_address(wm_address),
        .wm_din    (wm_din),
        .wm_ce     (wm_ce),
        .wm_we     (wm_we),
        .wm_dout   (wm_dout),
        .rd_addr   (rd_addr),
        .rd_en     (rd_en),
        .rd_data   (rd_data)
    );

    dtpu_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .cs_start       (cs_start),
        .cs_continue    (cs_continue),
        .infifo_is_empty(infifo_is_empty),
        .infifo_dout    (infifo_dout),
        .outfifo_is_full(outfifo_is_full),
        .res_lanes      (res_lanes),
        .busy           (busy),
        .cs_idle        (cs_idle),
        .cs_ready       (cs_ready),
        .cs_done        (cs_done),
        .infifo_read    (infifo_read),
        .outfifo_write  (outfifo_write),
        .outfifo_din    (outfifo_din),
        .rd_addr        (rd_addr),
        .rd_en          (rd_en),
        .weight_load    (weight_load),
        .advance        (advance),
        .in_lanes       (in_lanes)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    // Row k enters k cycles late
    generate
        for (genvar k = 0; k < ROWS; k++) begin : g_in_skew
            dtpu_skew #(.T(lane_t), .DEPTH(k)) u_skew (
                .clk    (clk),
                .rst_n  (rst_n),
                .advance(advance),
                .d      (in_lanes[k]),
                .q      (x_lanes[k])
            );
            assign x_vec[k] = x_lanes[k].data;
        end
    endgenerate

    // Bottom row valid drives the column valid chain
    dtpu_systolic_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .weight_load(weight_load),
        .weights    (rd_data),
        .x          (x_vec),
        .x_valid    (x_lanes[ROWS-1].valid),
        .psum       (psum),
        .psum_valid (psum_valid)
    );

    // Column j waits COLS-1-j cycles to line up with the last column
    generate
        for (genvar j = 0; j < COLS; j++) begin : g_out_deskew
            assign res_raw[j].valid = psum_valid[j];
            assign res_raw[j].data  = psum[j];
            dtpu_skew #(.T(res_lane_t), .DEPTH(COLS - 1 - j)) u_skew (
                .clk    (clk),
                .rst_n  (rst_n),
                .advance(advance),
                .d      (res_raw[j]),
                .q      (res_lanes[j])
            );
        end
    endgenerate

endmodule

// ==== hw/dtpu_ctrl.sv ====
`timescale 1ns/10ps

module dtpu_ctrl (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  dtpu_pkg::run_cfg_t                        cfg,
    input  logic                                      cs_start,
    input  logic                                      cs_continue,
    input  logic                                      infifo_is_empty,
    input  logic [dtpu_pkg::FIFO_W-1:0]               infifo_dout,
    input  logic                                      outfifo_is_full,
    input  dtpu_pkg::res_lane_t [dtpu_pkg::COLS-1:0]  res_lanes,
    output logic                                      busy,
    output logic                                      cs_idle,
    output logic                                      cs_ready,
    output logic                                      cs_done,
    output logic                                      infifo_read,
    output logic                                      outfifo_write,
    output logic [dtpu_pkg::FIFO_W-1:0]               outfifo_din,
    output logic [dtpu_pkg::WMEM_AW-1:0]              rd_addr,
    output logic                                      rd_en,
    output logic                                      weight_load,
    output logic                                      advance,
    output dtpu_pkg::lane_t [dtpu_pkg::ROWS-1:0]      in_lanes
);
    import dtpu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_LOAD, S_STREAM, S_DRAIN, S_DONE
    } state_t;

    state_t   state;
    state_t   state_nxt;
    logic [15:0] count_q;
    logic [15:0] rd_cnt;
    logic [15:0] wr_cnt;
    logic     last_rd;
    logic     last_wr;
    in_vec_t  in_word;
    logic     out_valid_q;
    out_vec_t out_data_q;

    ////////////////////////////////////////////////////////////
    // Strobes and levels
    ////////////////////////////////////////////////////////////

    // Full output FIFO freezes the whole datapath
    assign advance     = (state == S_STREAM || state == S_DRAIN) && !outfifo_is_full;
    assign infifo_read = (state == S_STREAM) && advance && !infifo_is_empty;

    assign last_rd  = rd_cnt == count_q - 16'd1;
    assign last_wr  = wr_cnt == count_q - 16'd1;
    assign cs_ready = infifo_read && last_rd;

    // Held word goes out on the next moving cycle
    assign outfifo_write = out_valid_q && advance;
    assign outfifo_din   = FIFO_W'(out_data_q);

    // Weight fetch
    assign rd_en       = state == S_FETCH;
    assign rd_addr     = cfg.waddr;
    assign weight_load = state == S_LOAD;

    assign cs_idle = state == S_IDLE;
    assign cs_done = state == S_DONE;
    assign busy    = !cs_idle && !cs_done;

    ////////////////////////////////////////////////////////////
    // Run FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            // Empty run skips the datapath
            S_IDLE:   if (cs_start) state_nxt = (cfg.count == '0) ? S_DONE : S_FETCH;
            S_FETCH:  state_nxt = S_LOAD;
            S_LOAD:   state_nxt = S_STREAM;
            S_STREAM: if (cs_ready) state_nxt = S_DRAIN;
            S_DRAIN:  if (outfifo_write && last_wr) state_nxt = S_DONE;
            S_DONE:   if (cs_continue) state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    // State and vector counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            count_q <= '0;
            rd_cnt  <= '0;
            wr_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (cs_start && cs_idle) begin
                count_q <= cfg.count;
                rd_cnt  <= '0;
                wr_cnt  <= '0;
            end else begin
                if (infifo_read) rd_cnt <= rd_cnt + 16'd1;
                if (outfifo_write) wr_cnt <= wr_cnt + 16'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Input lanes and output word
    ////////////////////////////////////////////////////////////

    // Low 12 bits of the FIFO word, element 0 lowest
    assign in_word = in_vec_t'(infifo_dout[$bits(in_vec_t)-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_lanes <= '0;
        end else if (advance) begin
            for (int k = 0; k < ROWS; k++) begin
                in_lanes[k].valid <= infifo_read;
                in_lanes[k].data  <= in_word[k];
            end
        end
    end

    // Column 0 valid marks a finished word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (advance) begin
            out_valid_q <= res_lanes[0].valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int j = 0; j < COLS; j++) begin
                out_data_q[j] <= res_lanes[j].data;
            end
        end
    end

endmodule

// ==== hw/dtpu_systolic_array.sv ====
`timescale 1ns/10ps

module dtpu_systolic_array (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        advance,
    input  logic                        weight_load,
    input  dtpu_pkg::weight_set_t       weights,
    input  dtpu_pkg::in_vec_t           x,
    input  logic                        x_valid,
    output dtpu_pkg::out_vec_t          psum,
    output logic [dtpu_pkg::COLS-1:0]   psum_valid
);
    import dtpu_pkg::*;

    // Horizontal input wires, one extra column at the right edge
    elem_t xh [ROWS][COLS+1];
    // Vertical partial sum wires, zero on top
    acc_t  pv [ROWS+1][COLS];

    logic [COLS-1:0] valid_q;

    ////////////////////////////////////////////////////////////
    // Cell grid
    ////////////////////////////////////////////////////////////

    generate
        for (genvar r = 0; r < ROWS; r++) begin : g_row_in
            assign xh[r][0] = x[r];
        end

        for (genvar c = 0; c < COLS; c++) begin : g_col_io
            assign pv[0][c] = '0;
            assign psum[c]  = pv[ROWS][c];
        end

        for (genvar r = 0; r < ROWS; r++) begin : g_row
            for (genvar c = 0; c < COLS; c++) begin : g_col
                dtpu_mac_cell u_cell (
                    .clk        (clk),
                    .rst_n      (rst_n),
                    .advance    (advance),
                    .weight_load(weight_load),
                    .w_in       (weights[r][c]),
                    .x_in       (xh[r][c]),
                    .psum_in    (pv[r][c]),
                    .x_out      (xh[r][c+1]),
                    .psum_out   (pv[r+1][c])
                );
            end
        end
    endgenerate

    // Valid follows the bottom row input across the columns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[COLS-2:0], x_valid};
        end
    end

    assign psum_valid = valid_q;

endmodule

// ==== hw/dtpu_mac_cell.sv ====
`timescale 1ns/10ps

module dtpu_mac_cell (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           advance,
    input  logic           weight_load,
    input  dtpu_pkg::elem_t w_in,
    input  dtpu_pkg::elem_t x_in,
    input  dtpu_pkg::acc_t  psum_in,
    output dtpu_pkg::elem_t x_out,
    output dtpu_pkg::acc_t  psum_out
);
    import dtpu_pkg::*;

    elem_t w_q;
    acc_t  prod;

    // Unsigned 4x4 product, widened
    assign prod = acc_t'(x_in) * acc_t'(w_q);

    // Stationary weight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_q <= '0;
        end else if (weight_load) begin
            w_q <= w_in;
        end
    end

    // Input right, partial sum down
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_out    <= '0;
            psum_out <= '0;
        end else if (advance) begin
            x_out    <= x_in;
            psum_out <= psum_in + prod;
        end
    end

endmodule

// ==== hw/dtpu_skew.sv ====
`timescale 1ns/10ps

module dtpu_skew #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic advance,
    input  T     d,
    output T     q
);

    generate
        if (DEPTH == 0) begin : g_pass
            // No delay for this lane
            assign q = d;
        end else begin : g_delay
            T stages [DEPTH];

            // Shift only when the pipeline moves
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stages[i] <= '0;
                    end
                end else if (advance) begin
                    stages[0] <= d;
                    for (int i = 1; i < DEPTH; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            // Oldest stage out
            assign q = stages[DEPTH-1];
        end
    endgenerate

endmodule

// ==== hw/dtpu_weight_mem.sv ====
`timescale 1ns/10ps

module dtpu_weight_mem (
    input  logic                         clk,
    input  logic [dtpu_pkg::WMEM_AW-1:0] wm_address,
    input  logic [dtpu_pkg::FIFO_W-1:0]  wm_din,
    input  logic                         wm_ce,
    input  logic                         wm_we,
    output logic [dtpu_pkg::FIFO_W-1:0]  wm_dout,
    input  logic [dtpu_pkg::WMEM_AW-1:0] rd_addr,
    input  logic                         rd_en,
    output dtpu_pkg::weight_set_t        rd_data
);
    import dtpu_pkg::*;

    // One weight set per word
    logic [FIFO_W-1:0] mem [WMEM_DEPTH];

    ////////////////////////////////////////////////////////////
    // Host port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wm_ce && wm_we) begin
            mem[wm_address] <= wm_din;
        end
    end

    // Readback for the host
    always_ff @(posedge clk) begin
        if (wm_ce && !wm_we) begin
            wm_dout <= mem[wm_address];
        end
    end

    ////////////////////////////////////////////////////////////
    // Fetch port toward the control FSM
    ////////////////////////////////////////////////////////////

    // Only the low 36 bits carry weights
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= weight_set_t'(mem[rd_addr][$bits(weight_set_t)-1:0]);
        end
    end

endmodule

// ==== hw/dtpu_csr.sv ====
`timescale 1ns/10ps

module dtpu_csr (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [dtpu_pkg::CSR_AW-1:0] csr_address,
    input  logic [7:0]                  csr_din,
    input  logic                        csr_ce,
    input  logic                        csr_we,
    input  logic                        busy,
    output logic [7:0]                  csr_dout,
    output dtpu_pkg::run_cfg_t          cfg
);
    import dtpu_pkg::*;

    logic [7:0] rd_byte;

    ////////////////////////////////////////////////////////////
    // Host writes
    ////////////////////////////////////////////////////////////

    // STATUS is read only, unmapped writes dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (csr_ce && csr_we) begin
            case (csr_address)
                CSR_COUNT_LO: cfg.count[7:0]  <= csr_din;
                CSR_COUNT_HI: cfg.count[15:8] <= csr_din;
                CSR_WADDR:    cfg.waddr       <= csr_din[WMEM_AW-1:0];
                default:      ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Host reads
    ////////////////////////////////////////////////////////////

    // Read mux, zero outside the map
    always_comb begin
        rd_byte = '0;
        case (csr_address)
            CSR_COUNT_LO: rd_byte = cfg.count[7:0];
            CSR_COUNT_HI: rd_byte = cfg.count[15:8];
            CSR_WADDR:    rd_byte = 8'(cfg.waddr);
            CSR_STATUS:   rd_byte = {7'b0, busy};
            default:      rd_byte = '0;
        endcase
    end

    // One cycle read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_dout <= '0;
        end else if (csr_ce && !csr_we) begin
            csr_dout <= rd_byte;
        end
    end

endmodule

// ==== hw/dtpu_pkg.sv ====
package dtpu_pkg;

    ////////////////////////////////////////////////////////////
    // Array and bus sizes
    ////////////////////////////////////////////////////////////

    localparam int DATA_W     = 4;
    localparam int ROWS       = 3;
    localparam int COLS       = 3;
    localparam int ACC_W      = 12;
    localparam int FIFO_W     = 64;
    localparam int WMEM_AW    = 4;
    localparam int WMEM_DEPTH = 1 << WMEM_AW;
    localparam int CSR_AW     = 32;

    // Read-to-write latency in advancing cycles
    localparam int PIPE_LAT = ROWS + COLS + 1;

    // CSR byte map
    localparam logic [CSR_AW-1:0] CSR_COUNT_LO = 32'd0;
    localparam logic [CSR_AW-1:0] CSR_COUNT_HI = 32'd1;
    localparam logic [CSR_AW-1:0] CSR_WADDR    = 32'd2;
    localparam logic [CSR_AW-1:0] CSR_STATUS   = 32'd3;

    ////////////////////////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////////////////////////

    typedef logic [DATA_W-1:0] elem_t;
    typedef logic [ACC_W-1:0]  acc_t;

    // Element 0 in the lowest bits
    typedef elem_t [ROWS-1:0] in_vec_t;
    typedef acc_t  [COLS-1:0] out_vec_t;

    // Weight (k, j) at flat index k*COLS + j
    typedef elem_t [ROWS-1:0][COLS-1:0] weight_set_t;

    typedef struct packed {
        logic [15:0]        count;
        logic [WMEM_AW-1:0] waddr;
    } run_cfg_t;

    // Input skew lane
    typedef struct packed {
        logic  valid;
        elem_t data;
    } lane_t;

    // Result deskew lane
    typedef struct packed {
        logic valid;
        acc_t data;
    } res_lane_t;

endpackage
